// File: sim.f
+incdir+hdl
hdl/usbRxPkg.sv
hdl/usbLineFrontend.sv
hdl/usbCrcChecker.sv
hdl/usbPacketReceiver.sv
hdl/usbRxByteOutput.sv
hdl/usbRxTop.sv
sim/usbRxTb.sv

// File: sim/usbRxTb.sv
`include "usbRx_settings.svh"

module usbRxTb;

    timeunit 1ns;
    timeprecision 100ps;

    import usbRxPkg::*;

    localparam int MaxTests = 20;
    // Symbols on the pair as {dp, dn}
    localparam logic [1:0] SymJ = 2'b10;
    localparam logic [1:0] SymSe0 = 2'b00;

    logic clk48;
    logic rxRST;
    logic dp;
    logic dn;
    logic rxAcceptNewData;
    rxByte_t rxData;
    logic rxDataValid;
    logic rxIsLastByte;
    logic keepPacket;

    // Test table, filled before reset is released
    logic [1:0] testSyms [MaxTests][$];
    rxByte_t expBytes [MaxTests][$];
    logic expKeep [MaxTests];
    int acceptDelay [MaxTests];
    string testName [MaxTests];
    int numTests = 0;
    longint totalSyms = 0;
    bit built = 0;

    int curTest = 0;
    int donePkts = 0;
    int holdCnt = 0;
    int byteErrors = 0;
    int keepErrors = 0;
    int otherErrors = 0;
    logic [31:0] rngState = 32'd22;

    usbRxTop u_usbRxTop (
        .clk48           (clk48),
        .rxRST           (rxRST),
        .dp              (dp),
        .dn              (dn),
        .rxAcceptNewData (rxAcceptNewData),
        .rxData          (rxData),
        .rxDataValid     (rxDataValid),
        .rxIsLastByte    (rxIsLastByte),
        .keepPacket      (keepPacket)
    );

    initial begin
        clk48 = 1'b0;
        forever #2 clk48 = ~clk48;
    end

    // ============================================================
    // Stimulus generation and reference model
    // ============================================================

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // USB CRC5 over the 11 token bits, field returned in send order
    function automatic logic [4:0] crc5Field(input logic [10:0] data);
        logic [4:0] crc;
        logic [4:0] field;
        logic fb;
        crc = '1;
        for (int i = 0; i < 11; i++) begin
            fb = crc[4] ^ data[i];
            crc = {crc[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
        end
        // Inverted remainder, top bit goes out first
        for (int i = 0; i < 5; i++) begin
            field[i] = ~crc[4-i];
        end
        return field;
    endfunction

    // CRC16 over the payload, PID excluded, appended low byte first
    function automatic void appendCrc16(inout logic [7:0] pkt[$]);
        logic [15:0] crc;
        logic [15:0] field;
        logic fb;
        crc = '1;
        for (int k = 1; k < pkt.size(); k++) begin
            for (int b = 0; b < 8; b++) begin
                fb = crc[15] ^ pkt[k][b];
                crc = {crc[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
            end
        end
        for (int i = 0; i < 16; i++) begin
            field[i] = ~crc[15-i];
        end
        pkt.push_back(field[7:0]);
        pkt.push_back(field[15:8]);
    endfunction

    function automatic void makeToken(input logic [7:0] pid, output logic [7:0] pkt[$]);
        logic [10:0] addrEndp;
        logic [15:0] body;
        addrEndp = 11'(nextRand());
        body = {crc5Field(addrEndp), addrEndp};
        pkt = {pid, body[7:0], body[15:8]};
    endfunction

    function automatic void makeData(input logic [7:0] pid, input int len,
                                     output logic [7:0] pkt[$]);
        pkt = {pid};
        for (int i = 0; i < len; i++) begin
            pkt.push_back(8'(nextRand()));
        end
        appendCrc16(pkt);
    endfunction

    // errKind 1 sends a one in the first stuffed slot, 2 turns one J bit into SE1
    function automatic void encodePacket(input logic [7:0] pkt[$], input int errKind,
                                         output logic [1:0] syms[$]);
        logic bitsQ[$];
        logic level;
        int ones;
        bit injected;
        syms = {};
        // SYNC is seven zeros and a one
        for (int i = 0; i < 8; i++) begin
            bitsQ.push_back(i == 7);
        end
        foreach (pkt[k]) begin
            for (int b = 0; b < 8; b++) begin
                bitsQ.push_back(pkt[k][b]);
            end
        end
        level = 1'b1;
        ones = 0;
        injected = 0;
        foreach (bitsQ[i]) begin
            // NRZI, a zero toggles the line
            level = bitsQ[i] ? level : ~level;
            syms.push_back({level, ~level});
            ones = bitsQ[i] ? ones + 1 : 0;
            if (ones == 6) begin
                if (errKind == 1 && !injected) begin
                    injected = 1;
                end else begin
                    level = ~level;
                end
                syms.push_back({level, ~level});
                ones = 0;
            end
        end
        if (errKind == 2) begin
            // Past SYNC and PID, same dp level so the bit value holds
            for (int i = 20; i < syms.size(); i++) begin
                if (syms[i] == SymJ) begin
                    syms[i] = 2'b11;
                    break;
                end
            end
        end
        syms.push_back(SymSe0);
        syms.push_back(SymSe0);
        syms.push_back(SymJ);
        // Idle gap
        for (int i = 0; i < 8; i++) begin
            syms.push_back(SymJ);
        end
    endfunction

    // Delivered bytes and keep flag as the receiver must report them
    function automatic void expectPacket(input logic [7:0] pkt[$], input bit errInjected,
                                         input bit overrunExp, output logic [7:0] exp[$],
                                         output logic keep);
        int count;
        count = pkt.size();
        // CRC16 field of a data packet stays inside
        if (count >= 3 && pkt[0][1:0] == `USB_DATA_TYPE) begin
            count = count - 2;
        end
        exp = {};
        for (int i = 0; i < count; i++) begin
            exp.push_back(pkt[i]);
        end
        keep = !(errInjected || overrunExp);
    endfunction

    task automatic addTest(input string name, input logic [7:0] pkt[$], input int errKind,
                           input int delay);
        logic [1:0] syms[$];
        logic [7:0] exp[$];
        logic keep;
        rxByte_t b;
        encodePacket(pkt, errKind, syms);
        // Holding a byte longer than two byte times must overrun
        expectPacket(pkt, errKind != 0, delay > 64, exp, keep);
        testSyms[numTests] = syms;
        foreach (exp[i]) begin
            b.raw = exp[i];
            expBytes[numTests].push_back(b);
        end
        expKeep[numTests] = keep;
        acceptDelay[numTests] = delay;
        testName[numTests] = name;
        totalSyms += syms.size();
        numTests++;
    endtask

    task automatic buildTests();
        logic [7:0] pkt[$];
        makeToken(8'h69, pkt);
        addTest("token_in", pkt, 0, 0);
        pkt = {8'hD2};
        addTest("ack", pkt, 0, 0);
        makeData(8'hC3, 0, pkt);
        addTest("data_empty", pkt, 0, 0);
        makeData(8'h4B, 16, pkt);
        addTest("data_full", pkt, 0, 0);
        for (int i = 0; i < 3; i++) begin
            makeData((i % 2) ? 8'h4B : 8'hC3, int'(nextRand() % 17), pkt);
            addTest("data_random", pkt, 0, 0);
        end
        // One payload bit flipped after the CRC was computed
        makeData(8'hC3, 4, pkt);
        pkt[2][3] = ~pkt[2][3];
        addTest("crc_error", pkt, 3, 0);
        pkt = {8'hF2};
        addTest("bad_pid", pkt, 3, 0);
        pkt = {8'hC3, 8'hFF, 8'h81};
        appendCrc16(pkt);
        addTest("stuff_error", pkt, 1, 0);
        makeData(8'h4B, 3, pkt);
        addTest("clean_after_stuff", pkt, 0, 0);
        pkt = {8'h4B, 8'h5A, 8'h3C};
        appendCrc16(pkt);
        addTest("se1_error", pkt, 2, 0);
        makeData(8'hC3, 3, pkt);
        addTest("clean_after_se1", pkt, 0, 0);
        makeData(8'hC3, 6, pkt);
        addTest("slow_accept", pkt, 0, 8);
        makeData(8'h4B, 4, pkt);
        addTest("overrun", pkt, 0, 80);
        pkt = {8'hD2};
        addTest("ack_after_overrun", pkt, 0, 0);
    endtask

    // ============================================================
    // Checks
    // ============================================================

    task automatic compareByte(input string name, input rxByte_t exp, input rxByte_t act);
        if (act.raw !== exp.raw) begin
            byteErrors++;
            $display("FAIL %s: byte expected %02h actual %02h", name, exp.raw, act.raw);
        end
    endtask

    task automatic compareKeep(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            keepErrors++;
            $display("FAIL %s: keepPacket expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic takeByte();
        bit lossy;
        rxByte_t exp;
        lossy = acceptDelay[curTest] > 64;
        // Overwritten bytes are lost, only the last one is checked then
        if (!(lossy && !rxIsLastByte)) begin
            if (expBytes[curTest].size() == 0) begin
                otherErrors++;
                $display("Error in %s: a byte arrived that was not expected",
                         testName[curTest]);
            end else begin
                if (lossy) begin
                    exp = expBytes[curTest][$];
                    expBytes[curTest] = {};
                end else begin
                    exp = expBytes[curTest].pop_front();
                end
                compareByte(testName[curTest], exp, rxData);
            end
        end
        if (rxIsLastByte) begin
            if (expBytes[curTest].size() != 0) begin
                otherErrors++;
                $display("Error in %s: packet ended with %0d bytes still missing",
                         testName[curTest], expBytes[curTest].size());
            end
            compareKeep(testName[curTest], expKeep[curTest], keepPacket);
            donePkts++;
        end
    endtask

    // Backend model, samples on the falling edge and answers with accept
    always @(negedge clk48) begin
        if (rxRST) begin
            rxAcceptNewData <= 1'b0;
            holdCnt = 0;
        end else if (rxDataValid) begin
            if (holdCnt >= acceptDelay[curTest]) begin
                rxAcceptNewData <= 1'b1;
                holdCnt = 0;
                takeByte();
            end else begin
                rxAcceptNewData <= 1'b0;
                holdCnt++;
            end
        end else begin
            rxAcceptNewData <= 1'b0;
            holdCnt = 0;
        end
    end

    // ============================================================
    // Driver and watchdog
    // ============================================================

    initial begin
        rxRST = 1'b1;
        dp = 1'b1;
        dn = 1'b0;
        rxAcceptNewData = 1'b0;
        buildTests();
        built = 1;
        repeat (16) @(posedge clk48);
        @(negedge clk48);
        rxRST = 1'b0;
        for (int t = 0; t < numTests; t++) begin
            curTest = t;
            for (int i = 0; i < testSyms[t].size(); i++) begin
                @(negedge clk48);
                {dp, dn} = testSyms[t][i];
                repeat (`USB_BIT_DIV - 1) @(negedge clk48);
            end
            // Next packet only once this one was reported
            wait (donePkts > t);
        end
        repeat (20) @(negedge clk48);
        $display("Errors: byte %0d, keep %0d, other %0d", byteErrors, keepErrors,
                 otherErrors);
        if (byteErrors + keepErrors + otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Line time of all packets plus room for reset and slow accepts
    initial begin
        longint limitNs;
        wait (built);
        limitNs = (16 + totalSyms * `USB_BIT_DIV + longint'(numTests) * 300) * 4;
        #(limitNs);
        $display("Timeout: test %s did not finish, %0d of %0d packets seen",
                 testName[curTest], donePkts, numTests);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: hdl/usbRxTop.sv
module usbRxTop (
    input  logic              clk48,
    input  logic              rxRST,
    input  logic              dp,
    input  logic              dn,
    input  logic              rxAcceptNewData,
    output usbRxPkg::rxByte_t rxData,
    output logic              rxDataValid,
    output logic              rxIsLastByte,
    output logic              keepPacket
);

    import usbRxPkg::*;

    // Front end to receiver
    lineBit_t lineBit;
    // Receiver to CRC checker
    logic crcClear;
    logic crcUse16;
    logic crcBit;
    logic crcBitStrobe;
    logic crcOk;
    // Receiver to output side
    logic byteStrobe;
    rxByte_t byteOut;
    logic byteIsLast;
    logic packetDropped;

    usbLineFrontend u_usbLineFrontend (
        .clk48   (clk48),
        .rxRST   (rxRST),
        .dp      (dp),
        .dn      (dn),
        .lineBit (lineBit)
    );

    usbPacketReceiver u_usbPacketReceiver (
        .clk48         (clk48),
        .rxRST         (rxRST),
        .lineBit       (lineBit),
        .crcClear      (crcClear),
        .crcUse16      (crcUse16),
        .crcBit        (crcBit),
        .crcBitStrobe  (crcBitStrobe),
        .crcOk         (crcOk),
        .byteStrobe    (byteStrobe),
        .byteOut       (byteOut),
        .byteIsLast    (byteIsLast),
        .packetDropped (packetDropped)
    );

    usbCrcChecker u_usbCrcChecker (
        .clk48        (clk48),
        .rxRST        (rxRST),
        .crcClear     (crcClear),
        .crcUse16     (crcUse16),
        .crcBit       (crcBit),
        .crcBitStrobe (crcBitStrobe),
        .crcOk        (crcOk)
    );

    usbRxByteOutput u_usbRxByteOutput (
        .clk48           (clk48),
        .rxRST           (rxRST),
        .byteStrobe      (byteStrobe),
        .byteOut         (byteOut),
        .byteIsLast      (byteIsLast),
        .packetDropped   (packetDropped),
        .rxAcceptNewData (rxAcceptNewData),
        .rxData          (rxData),
        .rxDataValid     (rxDataValid),
        .rxIsLastByte    (rxIsLastByte),
        .keepPacket      (keepPacket)
    );

endmodule

// File: hdl/usbRxByteOutput.sv
module usbRxByteOutput (
    input  logic              clk48,
    input  logic              rxRST,
    input  logic              byteStrobe,
    input  usbRxPkg::rxByte_t byteOut,
    input  logic              byteIsLast,
    input  logic              packetDropped,
    input  logic              rxAcceptNewData,
    output usbRxPkg::rxByte_t rxData,
    output logic              rxDataValid,
    output logic              rxIsLastByte,
    output logic              keepPacket
);

    // Flags that travel with the held byte
    logic lastHeld;
    logic dropHeld;
    // A byte was replaced before the backend took it
    logic overrun;

    // ==========================================================
    // Hold register and handshake
    // ==========================================================

    always_ff @(posedge clk48) begin
        if (byteStrobe) begin
            rxData <= byteOut;
        end
    end

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            rxDataValid <= 1'b0;
            lastHeld <= 1'b0;
            dropHeld <= 1'b0;
            overrun <= 1'b0;
        end else if (byteStrobe) begin
            rxDataValid <= 1'b1;
            lastHeld <= byteIsLast;
            dropHeld <= packetDropped;
            // Old overrun belongs to the previous packet once its last byte was held
            overrun <= (overrun & ~lastHeld) | (rxDataValid & ~rxAcceptNewData);
        end else if (rxAcceptNewData) begin
            rxDataValid <= 1'b0;
        end
    end

    assign rxIsLastByte = lastHeld & rxDataValid;
    // Sampled by the backend together with the last byte
    assign keepPacket = ~(dropHeld | overrun);

    // Output stays quiet through and right after reset
    assert property (@(posedge clk48) rxRST |=> !rxDataValid);

endmodule

// File: hdl/usbPacketReceiver.sv
`include "usbRx_settings.svh"

module usbPacketReceiver (
    input  logic               clk48,
    input  logic               rxRST,
    input  usbRxPkg::lineBit_t lineBit,
    output logic               crcClear,
    output logic               crcUse16,
    output logic               crcBit,
    output logic               crcBitStrobe,
    input  logic               crcOk,
    output logic               byteStrobe,
    output usbRxPkg::rxByte_t  byteOut,
    output logic               byteIsLast,
    output logic               packetDropped
);

    import usbRxPkg::*;

    rxState_t rxState;
    // Deserializer, LSB arrives first and ends up at bit 0
    logic [7:0] shiftReg;
    logic [2:0] bitCnt;
    rxByte_t assembled;
    logic inPacket;
    logic bytePush;
    logic syncMatch;
    logic pidOk;
    // CRC flag of the most recent payload byte
    logic lastByteCrcOk;
    logic [1:0] crcLatchDly;
    logic [1:0] flushCnt;
    logic doShift;
    // Three byte delay line, stage 2 is the oldest
    rxByte_t dlyByte [0:2];
    logic [2:0] dlyData;
    logic [2:0] dlyLast;

    // Byte as it looks including the bit on the line now
    assign assembled.raw = {lineBit.bitData, shiftReg[7:1]};

    assign inPacket = (rxState == getPid) || (rxState == waitEop);
    assign bytePush = lineBit.bitStrobe && (bitCnt == 3'd7) && inPacket;
    assign syncMatch = lineBit.bitStrobe && (rxState == waitSync)
        && (assembled.raw[7:4] == `USB_SYNC_NIBBLE);
    assign pidOk = (assembled.pid.checkN == ~assembled.pid.pidCode);
    assign doShift = bytePush || (flushCnt != 2'd0);

    // CRC sees every data bit directly
    assign crcBit = lineBit.bitData;
    assign crcBitStrobe = lineBit.bitStrobe;

    // ==========================================================
    // Deserializer
    // ==========================================================

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            // Idle line decodes as ones
            shiftReg <= '1;
            bitCnt <= '0;
        end else if (lineBit.bitStrobe) begin
            shiftReg <= assembled.raw;
            // SYNC end realigns byte boundaries
            bitCnt <= syncMatch ? 3'd0 : bitCnt + 3'd1;
        end else if (lineBit.eop) begin
            // Tail bits of a packet must not pass for the next SYNC
            shiftReg <= '1;
        end
    end

    // ==========================================================
    // Packet FSM and drop flag
    // ==========================================================

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            rxState <= waitSync;
            packetDropped <= 1'b0;
            crcClear <= 1'b0;
            crcUse16 <= 1'b0;
            lastByteCrcOk <= 1'b1;
            crcLatchDly <= '0;
            flushCnt <= '0;
        end else begin
            crcClear <= 1'b0;
            // crcOk settles two cycles after the last bit of a byte
            crcLatchDly <= {crcLatchDly[0], bytePush && (rxState == waitEop)};
            if (crcLatchDly[1]) begin
                lastByteCrcOk <= crcOk;
            end
            if (flushCnt != 2'd0) begin
                flushCnt <= flushCnt - 2'd1;
            end
            // Signal errors count only inside a packet
            if (inPacket && (lineBit.lineError || lineBit.stuffError)) begin
                packetDropped <= 1'b1;
            end
            case (rxState)
                waitSync: begin
                    if (syncMatch) begin
                        rxState <= getPid;
                        packetDropped <= 1'b0;
                    end
                end
                getPid: begin
                    if (lineBit.eop) begin
                        // Packet ended before its PID
                        rxState <= endPhase;
                        packetDropped <= 1'b1;
                    end else if (bytePush) begin
                        rxState <= waitEop;
                        crcClear <= 1'b1;
                        crcUse16 <= (assembled.pid.pidCode[1:0] == `USB_DATA_TYPE);
                        if (!pidOk) begin
                            packetDropped <= 1'b1;
                        end
                    end
                end
                waitEop: begin
                    if (lineBit.eop) begin
                        rxState <= endPhase;
                        flushCnt <= 2'd3;
                        if (!lastByteCrcOk) begin
                            packetDropped <= 1'b1;
                        end
                    end
                end
                endPhase: begin
                    // Handshake packets carry no CRC
                    rxState <= waitSync;
                    lastByteCrcOk <= 1'b1;
                end
            endcase
        end
    end

    // ==========================================================
    // Byte delay line
    // ==========================================================

    // Tags shift with the bytes, eop rewrites them in place
    always_ff @(posedge clk48) begin
        if (rxRST) begin
            dlyData <= '0;
            dlyLast <= '0;
            byteStrobe <= 1'b0;
            byteIsLast <= 1'b0;
        end else if (doShift) begin
            byteStrobe <= dlyData[2];
            byteIsLast <= dlyData[2] & dlyLast[2];
            dlyData <= {dlyData[1:0], bytePush};
            dlyLast <= {dlyLast[1:0], 1'b0};
        end else begin
            byteStrobe <= 1'b0;
            byteIsLast <= 1'b0;
            if (lineBit.eop && (rxState == waitEop)) begin
                if (crcUse16) begin
                    // Two newest bytes are the CRC16 field
                    dlyData[1:0] <= 2'b00;
                    dlyLast[2] <= 1'b1;
                end else begin
                    dlyLast[0] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (doShift) begin
            byteOut <= dlyByte[2];
            dlyByte[2] <= dlyByte[1];
            dlyByte[1] <= dlyByte[0];
            dlyByte[0] <= assembled;
        end
    end

    // Last byte only leaves during the flush after eop
    assert property (@(posedge clk48) disable iff (rxRST)
        byteIsLast |-> byteStrobe && (rxState inside {endPhase, waitSync}));

endmodule

// File: hdl/usbCrcChecker.sv
`include "usbRx_settings.svh"

module usbCrcChecker (
    input  logic clk48,
    input  logic rxRST,
    input  logic crcClear,
    input  logic crcUse16,
    input  logic crcBit,
    input  logic crcBitStrobe,
    output logic crcOk
);

    // Generator polynomials without the top term
    localparam logic [4:0] Poly5 = 5'b00101;
    localparam logic [15:0] Poly16 = 16'h8005;

    // CRC5 lives in the low five bits
    logic [15:0] crcReg;
    logic fb5;
    logic fb16;

    // ==========================================================
    // Serial update
    // ==========================================================

    // Feedback from the top bit of the active width
    assign fb5 = crcReg[4] ^ crcBit;
    assign fb16 = crcReg[15] ^ crcBit;

    always_ff @(posedge clk48) begin
        if (rxRST || crcClear) begin
            // Preset to all ones at packet start
            crcReg <= '1;
        end else if (crcBitStrobe) begin
            if (crcUse16) begin
                crcReg <= {crcReg[14:0], 1'b0} ^ (fb16 ? Poly16 : 16'h0000);
            end else begin
                crcReg <= {11'b0, crcReg[3:0], 1'b0} ^ {11'b0, (fb5 ? Poly5 : 5'b00000)};
            end
        end
    end

    // ==========================================================
    // Residue match
    // ==========================================================

    // Registered compare, valid one cycle after the update
    always_ff @(posedge clk48) begin
        if (rxRST) begin
            crcOk <= 1'b0;
        end else if (crcUse16) begin
            crcOk <= (crcReg == `USB_CRC16_RESIDUE);
        end else begin
            crcOk <= (crcReg[4:0] == `USB_CRC5_RESIDUE);
        end
    end

endmodule

// File: hdl/usbLineFrontend.sv
`include "usbRx_settings.svh"

module usbLineFrontend (
    input  logic               clk48,
    input  logic               rxRST,
    input  logic               dp,
    input  logic               dn,
    output usbRxPkg::lineBit_t lineBit
);

    // Divider width and terminal count
    localparam int DivW = $clog2(`USB_BIT_DIV);
    localparam int DivLast = `USB_BIT_DIV - 1;

    logic [DivW-1:0] divCnt;
    logic sampleStrobe;
    // Sampled pair plus its valid pulse
    logic sDp;
    logic sDn;
    logic sampleValid;
    // Decoded line states of the sample
    logic lineSe0;
    logic lineSe1;
    logic lineJ;
    // NRZI reference level and stuffing state
    logic prevLevel;
    logic decoded;
    logic [2:0] onesCnt;
    logic stuffSlot;
    logic seenSe0;

    // ==========================================================
    // Bit strobe and sampling
    // ==========================================================

    // Free running divider, one sample per bit time
    assign sampleStrobe = (divCnt == DivW'(DivLast));

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            divCnt <= '0;
        end else if (sampleStrobe) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // Pair is captured once per bit
    always_ff @(posedge clk48) begin
        if (sampleStrobe) begin
            sDp <= dp;
            sDn <= dn;
        end
    end

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= sampleStrobe;
        end
    end

    // ==========================================================
    // Line state, NRZI and unstuffing
    // ==========================================================

    assign lineSe0 = ~sDp & ~sDn;
    assign lineSe1 = sDp & sDn;
    assign lineJ = sDp & ~sDn;
    // No transition decodes as one
    assign decoded = (sDp == prevLevel);
    // Bit after six ones is the stuffed zero
    assign stuffSlot = (onesCnt == 3'd6);

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            lineBit <= '0;
            prevLevel <= 1'b1;
            onesCnt <= '0;
            seenSe0 <= 1'b0;
        end else begin
            // Event fields are single cycle pulses
            lineBit.bitStrobe <= 1'b0;
            lineBit.stuffError <= 1'b0;
            lineBit.lineError <= 1'b0;
            lineBit.eop <= 1'b0;
            if (sampleValid) begin
                if (lineSe0) begin
                    seenSe0 <= 1'b1;
                end else if (seenSe0 && lineJ) begin
                    // End of packet, decoder back to idle J
                    seenSe0 <= 1'b0;
                    lineBit.eop <= 1'b1;
                    prevLevel <= 1'b1;
                    onesCnt <= '0;
                end else begin
                    seenSe0 <= 1'b0;
                    prevLevel <= sDp;
                    lineBit.lineError <= lineSe1;
                    lineBit.bitData <= decoded;
                    if (stuffSlot) begin
                        // Stuffed bit is dropped, a one here is a violation
                        onesCnt <= '0;
                        lineBit.stuffError <= decoded;
                    end else begin
                        onesCnt <= decoded ? onesCnt + 3'd1 : 3'd0;
                        lineBit.bitStrobe <= 1'b1;
                    end
                end
            end
        end
    end

    // Bits are at least one divider period apart
    assert property (@(posedge clk48) disable iff (rxRST)
        lineBit.bitStrobe |=> !lineBit.bitStrobe);

endmodule

// File: hdl/usbRxPkg.sv
package usbRxPkg;

    // ==========================================================
    // Front end to packet receiver
    // ==========================================================

    // One decoded line event per clk48 cycle
    typedef struct packed {
        // Pulse per data bit, stuffed bits excluded
        logic bitStrobe;
        // Bit value after NRZI decoding
        logic bitData;
        // Stuffed slot held a one
        logic stuffError;
        // SE1 seen on the pair
        logic lineError;
        // First J after SE0
        logic eop;
    } lineBit_t;

    // ==========================================================
    // Received byte
    // ==========================================================

    // PID byte as sent, complement in the upper nibble
    typedef struct packed {
        logic [3:0] checkN;
        logic [3:0] pidCode;
    } pidField_t;

    // First byte of a packet is read as PID, the rest as raw data
    typedef union packed {
        logic [7:0] raw;
        pidField_t pid;
    } rxByte_t;

    // ==========================================================
    // Packet receiver FSM
    // ==========================================================

    typedef enum logic [1:0] {
        waitSync = 2'd0,
        getPid   = 2'd1,
        waitEop  = 2'd2,
        endPhase = 2'd3
    } rxState_t;

endpackage

// File: hdl/usbRx_settings.svh
`ifndef USB_RX_SETTINGS_SVH
`define USB_RX_SETTINGS_SVH

// ==========================================================
// Line timing
// ==========================================================

// clk48 cycles per full-speed bit
`define USB_BIT_DIV 4

// ==========================================================
// Packet framing
// ==========================================================

// Upper nibble of the deserializer right after the last SYNC bit
`define USB_SYNC_NIBBLE 4'b1000

// PID type bits [1:0] of DATA0/DATA1/DATA2/MDATA
`define USB_DATA_TYPE 2'b11

// Remainders left in the CRC registers after a good packet
// including the transmitted CRC field
`define USB_CRC5_RESIDUE 5'b01100
`define USB_CRC16_RESIDUE 16'h800D

`endif
